// ==== verilog/pwm_regs_pkg.sv ====
`default_nettype none

package pwm_regs_pkg;

	localparam int DATA_W   = 32;
	localparam int ADDR_W   = 32;
	localparam int OFFSET_W = 8;
	localparam int MODE_W   = 2;
	localparam int STEP_W   = 12;
	localparam int LANE_W   = 4;

	// register window
	localparam logic [ADDR_W-1:0] PWM_BASE_ADDR   = 32'h2002_0000;
	localparam logic [ADDR_W-1:0] PWM_OFFSET_MASK = 32'h0000_00ff;

	// register index, offset bits [5:3]
	localparam logic [2:0] REG_MODE   = 3'd0;
	localparam logic [2:0] REG_PERIOD = 3'd1;
	localparam logic [2:0] REG_THR1   = 3'd2;
	localparam logic [2:0] REG_THR2   = 3'd3;
	localparam logic [2:0] REG_STEP   = 3'd4;
	localparam logic [2:0] REG_STATUS = 3'd5;  // read only

	localparam logic [2:0] REG_LAST_WRITABLE = REG_STEP;

	// size / strobe word, word wins over half, byte always set
	localparam int LANE_WORD_BIT = 3;
	localparam int LANE_HALF_BIT = 1;

	// byte offset inside the window, seen as a whole or split into fields
	typedef union packed {
		logic [OFFSET_W-1:0] raw;
		struct packed {
			logic [1:0] pad;
			logic [2:0] reg_sel;
			logic       chan;      // 0 -> pwm1, 1 -> pwm2
			logic [1:0] byte_off;
		} fields;
	} pwm_offset_u;

endpackage

`default_nettype wire

// ==== verilog/reg_access_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if ();
	import pwm_regs_pkg::*;

	logic              wr_en;      // mapped, writable commit
	logic              rd_en;      // any accepted read
	pwm_offset_u       offset;     // follows the read side
	pwm_offset_u       wr_offset;
	logic [LANE_W-1:0] lanes;      // read size
	logic [LANE_W-1:0] wr_lanes;   // write strobe
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata_ch0;
	logic [DATA_W-1:0] rdata_ch1;

	// write side has its own offset and lanes so a read and a write can commit together
	modport ctrl (
		output wr_en, rd_en, offset, wr_offset, lanes, wr_lanes, wdata
	);

	modport bank (
		input  wr_en, offset, wr_offset, wr_lanes, wdata,
		output rdata_ch0, rdata_ch1
	);

	modport shaper (
		input  rd_en, offset, lanes, rdata_ch0, rdata_ch1
	);

endinterface

`default_nettype wire

// ==== verilog/pwm_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_bus_ctrl (
	input  wire                                s_axi_aclk_i,
	input  wire                                s_axi_aresetn_i,

	input  wire  [pwm_regs_pkg::ADDR_W-1:0]    s_axi_araddr_i,
	input  wire                                s_axi_arvalid_i,
	output logic                               s_axi_arready_o,
	input  wire                                s_axi_rready_i,
	output logic                               s_axi_rvalid_o,
	output logic                               s_axi_rresp_o,
	input  wire  [pwm_regs_pkg::LANE_W-1:0]    read_size_i,

	input  wire  [pwm_regs_pkg::ADDR_W-1:0]    s_axi_awaddr_i,
	input  wire                                s_axi_awvalid_i,
	output logic                               s_axi_awready_o,
	input  wire  [pwm_regs_pkg::DATA_W-1:0]    s_axi_wdata_i,
	input  wire  [pwm_regs_pkg::LANE_W-1:0]    s_axi_wstrb_i,
	input  wire                                s_axi_wvalid_i,
	output logic                               s_axi_wready_o,
	input  wire                                s_axi_bready_i,
	output logic                               s_axi_bvalid_o,
	output logic                               s_axi_bresp_o,

	reg_access_if.ctrl                         acc
);
	import pwm_regs_pkg::*;

	logic              rd_state;  // 0 idle, 1 waiting for rready
	logic              wr_state;  // 0 idle, 1 waiting for bready
	pwm_offset_u       rd_offset_q;
	pwm_offset_u       wr_offset_q;
	logic [LANE_W-1:0] rd_size_q;
	logic [LANE_W-1:0] wr_strb_q;
	logic [DATA_W-1:0] wdata_q;
	logic              ar_hit;
	logic              aw_hit;
	logic              rd_accept;
	logic              wr_accept;
	logic              rd_done;
	logic              wr_done;
	logic              rd_mapped;
	logic              wr_writable;

	function automatic logic offset_mapped(input pwm_offset_u off);
		return (off.fields.pad == 2'b00) && (off.fields.byte_off == 2'b00) &&
			(off.fields.reg_sel <= REG_STATUS);
	endfunction

	// base window match, anything outside gets no ready at all
	assign ar_hit = s_axi_arvalid_i &&
		((s_axi_araddr_i & ~PWM_OFFSET_MASK) == PWM_BASE_ADDR);
	assign aw_hit = s_axi_awvalid_i && s_axi_wvalid_i &&
		((s_axi_awaddr_i & ~PWM_OFFSET_MASK) == PWM_BASE_ADDR);

	assign rd_accept = !rd_state && ar_hit;
	assign wr_accept = !wr_state && aw_hit;
	assign rd_done   = rd_state && s_axi_rready_i;
	assign wr_done   = wr_state && s_axi_bready_i;

	assign rd_mapped   = offset_mapped(rd_offset_q);
	assign wr_writable = offset_mapped(wr_offset_q) &&
		(wr_offset_q.fields.reg_sel <= REG_LAST_WRITABLE);

	// ready is high for the whole wait state
	assign s_axi_arready_o = rd_state;
	assign s_axi_awready_o = wr_state;
	assign s_axi_wready_o  = wr_state;

	assign acc.rd_en     = rd_done;
	assign acc.wr_en     = wr_done && wr_writable;
	assign acc.offset    = rd_offset_q;
	assign acc.wr_offset = wr_offset_q;
	assign acc.lanes     = rd_size_q;
	assign acc.wr_lanes  = wr_strb_q;
	assign acc.wdata     = wdata_q;

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			rd_state       <= 1'b0;
			rd_offset_q    <= '0;
			s_axi_rvalid_o <= 1'b0;
			s_axi_rresp_o  <= 1'b0;
		end else begin
			s_axi_rvalid_o <= rd_done;              // one cycle pulse
			s_axi_rresp_o  <= rd_done && rd_mapped;
			if (rd_done) begin
				rd_state <= 1'b0;
			end else if (rd_accept) begin
				rd_state        <= 1'b1;
				rd_offset_q.raw <= s_axi_araddr_i[OFFSET_W-1:0];
			end
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			wr_state       <= 1'b0;
			wr_offset_q    <= '0;
			s_axi_bvalid_o <= 1'b0;
			s_axi_bresp_o  <= 1'b0;
		end else begin
			s_axi_bvalid_o <= wr_done;
			s_axi_bresp_o  <= wr_done && wr_writable;  // status and holes answer 0
			if (wr_done) begin
				wr_state <= 1'b0;
			end else if (wr_accept) begin
				wr_state        <= 1'b1;
				wr_offset_q.raw <= s_axi_awaddr_i[OFFSET_W-1:0];
			end
		end
	end

	// payload captured at acceptance
	always_ff @(posedge s_axi_aclk_i) begin
		if (rd_accept) begin
			rd_size_q <= read_size_i;
		end
		if (wr_accept) begin
			wr_strb_q <= s_axi_wstrb_i;
			wdata_q   <= s_axi_wdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pwm_channel_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_channel_regs #(
	parameter bit CHAN_ID = 1'b0
) (
	input  wire                               s_axi_aclk_i,
	input  wire                               s_axi_aresetn_i,
	input  wire                               pwm_i,
	output logic [pwm_regs_pkg::MODE_W-1:0]   mode_o,
	output logic [pwm_regs_pkg::DATA_W-1:0]   period_o,
	output logic [pwm_regs_pkg::DATA_W-1:0]   threshold1_o,
	output logic [pwm_regs_pkg::DATA_W-1:0]   threshold2_o,
	output logic [pwm_regs_pkg::STEP_W-1:0]   step_o,
	reg_access_if.bank                        acc
);
	import pwm_regs_pkg::*;

	logic [MODE_W-1:0] mode_q;
	logic [DATA_W-1:0] period_q;
	logic [DATA_W-1:0] thr1_q;
	logic [DATA_W-1:0] thr2_q;
	logic [STEP_W-1:0] step_q;
	logic              status_q;
	logic              wr_hit;
	logic [DATA_W-1:0] step_merged;
	logic [DATA_W-1:0] rd_word;

	// byte lane always written, then word or half on top
	function automatic logic [DATA_W-1:0] lane_merge(
		input logic [DATA_W-1:0] old_val,
		input logic [DATA_W-1:0] new_val,
		input logic [LANE_W-1:0] lanes
	);
		logic [DATA_W-1:0] res;
		res      = old_val;
		res[7:0] = new_val[7:0];
		if (lanes[LANE_WORD_BIT]) begin
			res[DATA_W-1:8] = new_val[DATA_W-1:8];
		end else if (lanes[LANE_HALF_BIT]) begin
			res[15:8] = new_val[15:8];
		end
		return res;
	endfunction

	assign wr_hit      = acc.wr_en && (acc.wr_offset.fields.chan == CHAN_ID);
	assign step_merged = lane_merge({{(DATA_W-STEP_W){1'b0}}, step_q}, acc.wdata, acc.wr_lanes);

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			mode_q   <= '0;
			period_q <= '0;
			thr1_q   <= '0;
			thr2_q   <= '0;
			step_q   <= '0;
			status_q <= 1'b0;
		end else begin
			status_q <= pwm_i;  // sampled every cycle
			if (wr_hit) begin
				case (acc.wr_offset.fields.reg_sel)
					REG_MODE:   mode_q   <= acc.wdata[MODE_W-1:0];
					REG_PERIOD: period_q <= lane_merge(period_q, acc.wdata, acc.wr_lanes);
					REG_THR1:   thr1_q   <= lane_merge(thr1_q, acc.wdata, acc.wr_lanes);
					REG_THR2:   thr2_q   <= lane_merge(thr2_q, acc.wdata, acc.wr_lanes);
					REG_STEP:   step_q   <= step_merged[STEP_W-1:0];
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (acc.offset.fields.reg_sel)
			REG_MODE:   rd_word = {{(DATA_W-MODE_W){1'b0}}, mode_q};
			REG_PERIOD: rd_word = period_q;
			REG_THR1:   rd_word = thr1_q;
			REG_THR2:   rd_word = thr2_q;
			REG_STEP:   rd_word = {{(DATA_W-STEP_W){1'b0}}, step_q};
			REG_STATUS: rd_word = {{(DATA_W-1){1'b0}}, status_q};
			default:    rd_word = '0;
		endcase
	end

	// each bank owns one of the read words
	if (CHAN_ID == 1'b0) begin : g_rd_ch0
		assign acc.rdata_ch0 = rd_word;
	end else begin : g_rd_ch1
		assign acc.rdata_ch1 = rd_word;
	end

	assign mode_o       = mode_q;
	assign period_o     = period_q;
	assign threshold1_o = thr1_q;
	assign threshold2_o = thr2_q;
	assign step_o       = step_q;

endmodule

`default_nettype wire

// ==== verilog/pwm_read_shaper.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_read_shaper (
	input  wire                               s_axi_aclk_i,
	input  wire                               s_axi_aresetn_i,
	output logic [pwm_regs_pkg::DATA_W-1:0]   s_axi_rdata_o,
	reg_access_if.shaper                      acc
);
	import pwm_regs_pkg::*;

	logic [DATA_W-1:0] sel_word;
	logic [DATA_W-1:0] lane_mask;
	logic [DATA_W-1:0] rdata_q;

	assign sel_word = acc.offset.fields.chan ? acc.rdata_ch1 : acc.rdata_ch0;

	// same lane rule as writes
	always_comb begin
		if (acc.lanes[LANE_WORD_BIT]) begin
			lane_mask = '1;
		end else if (acc.lanes[LANE_HALF_BIT]) begin
			lane_mask = {{(DATA_W-16){1'b0}}, 16'hffff};
		end else begin
			lane_mask = {{(DATA_W-8){1'b0}}, 8'hff};
		end
	end

	// held until the next read
	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			rdata_q <= '0;
		end else if (acc.rd_en) begin
			rdata_q <= sel_word & lane_mask;
		end
	end

	assign s_axi_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/pwm_axi_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_axi_regs_top (
	input  wire                               s_axi_aclk_i,
	input  wire                               s_axi_aresetn_i,

	// read address and data
	input  wire  [pwm_regs_pkg::ADDR_W-1:0]   s_axi_araddr_i,
	input  wire                               s_axi_arvalid_i,
	output wire                               s_axi_arready_o,
	input  wire                               s_axi_rready_i,
	output wire                               s_axi_rvalid_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   s_axi_rdata_o,
	output wire                               s_axi_rresp_o,   // 1 ok, 0 unmapped
	input  wire  [pwm_regs_pkg::LANE_W-1:0]   read_size_i,

	// write address, data and response
	input  wire  [pwm_regs_pkg::ADDR_W-1:0]   s_axi_awaddr_i,
	input  wire                               s_axi_awvalid_i,
	output wire                               s_axi_awready_o,
	input  wire  [pwm_regs_pkg::DATA_W-1:0]   s_axi_wdata_i,
	input  wire  [pwm_regs_pkg::LANE_W-1:0]   s_axi_wstrb_i,
	input  wire                               s_axi_wvalid_i,
	output wire                               s_axi_wready_o,
	input  wire                               s_axi_bready_i,
	output wire                               s_axi_bvalid_o,
	output wire                               s_axi_bresp_o,

	output wire  [pwm_regs_pkg::MODE_W-1:0]   pwm1_mode_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   pwm1_period_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   pwm1_threshold1_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   pwm1_threshold2_o,
	output wire  [pwm_regs_pkg::STEP_W-1:0]   pwm1_step_o,
	input  wire                               pwm1_i,

	output wire  [pwm_regs_pkg::MODE_W-1:0]   pwm2_mode_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   pwm2_period_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   pwm2_threshold1_o,
	output wire  [pwm_regs_pkg::DATA_W-1:0]   pwm2_threshold2_o,
	output wire  [pwm_regs_pkg::STEP_W-1:0]   pwm2_step_o,
	input  wire                               pwm2_i
);

	reg_access_if acc_if ();

	pwm_bus_ctrl i_bus_ctrl (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.read_size_i     (read_size_i),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wstrb_i   (s_axi_wstrb_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.acc             (acc_if.ctrl)
	);

	// pwm1 is channel 0
	pwm_channel_regs #(
		.CHAN_ID (1'b0)
	) i_ch0_regs (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.pwm_i           (pwm1_i),
		.mode_o          (pwm1_mode_o),
		.period_o        (pwm1_period_o),
		.threshold1_o    (pwm1_threshold1_o),
		.threshold2_o    (pwm1_threshold2_o),
		.step_o          (pwm1_step_o),
		.acc             (acc_if.bank)
	);

	pwm_channel_regs #(
		.CHAN_ID (1'b1)
	) i_ch1_regs (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.pwm_i           (pwm2_i),
		.mode_o          (pwm2_mode_o),
		.period_o        (pwm2_period_o),
		.threshold1_o    (pwm2_threshold1_o),
		.threshold2_o    (pwm2_threshold2_o),
		.step_o          (pwm2_step_o),
		.acc             (acc_if.bank)
	);

	pwm_read_shaper i_read_shaper (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.acc             (acc_if.shaper)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_pwm_axi_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_axi_regs;
	import pwm_regs_pkg::*;

	localparam int NUM_TXN  = 80;
	localparam int WDOG_CYC = NUM_TXN * 20 + 200;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic              rready;
	logic              rvalid;
	logic [DATA_W-1:0] rdata;
	logic              rresp;
	logic [LANE_W-1:0] rsize;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic [LANE_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	logic              bready;
	logic              bvalid;
	logic              bresp;
	logic              pwm1;
	logic              pwm2;
	logic [MODE_W-1:0] mode1;
	logic [DATA_W-1:0] period1;
	logic [DATA_W-1:0] thr1_1;
	logic [DATA_W-1:0] thr2_1;
	logic [STEP_W-1:0] step1;
	logic [MODE_W-1:0] mode2;
	logic [DATA_W-1:0] period2;
	logic [DATA_W-1:0] thr1_2;
	logic [DATA_W-1:0] thr2_2;
	logic [STEP_W-1:0] step2;

	logic [DATA_W-1:0] model [2][5];  // expected register contents
	logic [7:0]        bad_wr [5] = '{8'h28, 8'h2c, 8'h30, 8'h05, 8'h80};
	logic [7:0]        bad_rd [3] = '{8'h30, 8'h01, 8'h40};
	int                val_errs   = 0;
	int                proto_errs = 0;

	pwm_axi_regs_top i_pwm_axi_regs_top (
		.s_axi_aclk_i      (clk),
		.s_axi_aresetn_i   (rst),
		.s_axi_araddr_i    (araddr),
		.s_axi_arvalid_i   (arvalid),
		.s_axi_arready_o   (arready),
		.s_axi_rready_i    (rready),
		.s_axi_rvalid_o    (rvalid),
		.s_axi_rdata_o     (rdata),
		.s_axi_rresp_o     (rresp),
		.read_size_i       (rsize),
		.s_axi_awaddr_i    (awaddr),
		.s_axi_awvalid_i   (awvalid),
		.s_axi_awready_o   (awready),
		.s_axi_wdata_i     (wdata),
		.s_axi_wstrb_i     (wstrb),
		.s_axi_wvalid_i    (wvalid),
		.s_axi_wready_o    (wready),
		.s_axi_bready_i    (bready),
		.s_axi_bvalid_o    (bvalid),
		.s_axi_bresp_o     (bresp),
		.pwm1_mode_o       (mode1),
		.pwm1_period_o     (period1),
		.pwm1_threshold1_o (thr1_1),
		.pwm1_threshold2_o (thr2_1),
		.pwm1_step_o       (step1),
		.pwm1_i            (pwm1),
		.pwm2_mode_o       (mode2),
		.pwm2_period_o     (period2),
		.pwm2_threshold1_o (thr1_2),
		.pwm2_threshold2_o (thr2_2),
		.pwm2_step_o       (step2),
		.pwm2_i            (pwm2)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_fault(input string what);
		$display("protocol error at %0t: %s", $time, what);
		proto_errs++;
	endtask

	task automatic check_value(input string tname, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] got);
		assert (got === exp) else begin
			$display("ERR %s: expected %h, actual %h", tname, exp, got);
			val_errs++;
		end
	endtask

	// word beats half beats byte
	function automatic logic [DATA_W-1:0] lane_mask_for(input logic [LANE_W-1:0] lanes);
		return lanes[LANE_WORD_BIT] ? 32'hffff_ffff :
			(lanes[LANE_HALF_BIT] ? 32'h0000_ffff : 32'h0000_00ff);
	endfunction

	function automatic logic [DATA_W-1:0] width_mask(input int r);
		return (r == 0) ? 32'h0000_0003 : ((r == 4) ? 32'h0000_0fff : 32'hffff_ffff);
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input int ch, input int r);
		return PWM_BASE_ADDR + r * 8 + ch * 4;
	endfunction

	task automatic model_write(input int ch, input int r, input logic [DATA_W-1:0] data,
		input logic [LANE_W-1:0] strb);
		logic [DATA_W-1:0] m;
		m = (r == 0) ? 32'h3 : lane_mask_for(strb);  // mode ignores lanes
		model[ch][r] = ((model[ch][r] & ~m) | (data & m)) & width_mask(r);
	endtask

	task automatic check_outputs(input string tname);
		check_value({tname, " pwm1_mode"}, model[0][0], {30'b0, mode1});
		check_value({tname, " pwm1_period"}, model[0][1], period1);
		check_value({tname, " pwm1_threshold1"}, model[0][2], thr1_1);
		check_value({tname, " pwm1_threshold2"}, model[0][3], thr2_1);
		check_value({tname, " pwm1_step"}, model[0][4], {20'b0, step1});
		check_value({tname, " pwm2_mode"}, model[1][0], {30'b0, mode2});
		check_value({tname, " pwm2_period"}, model[1][1], period2);
		check_value({tname, " pwm2_threshold1"}, model[1][2], thr1_2);
		check_value({tname, " pwm2_threshold2"}, model[1][3], thr2_2);
		check_value({tname, " pwm2_step"}, model[1][4], {20'b0, step2});
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [LANE_W-1:0] strb, input int stall, output logic resp);
		int waited;
		resp    = 1'b0;
		waited  = 0;
		@(negedge clk);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = strb;
		wvalid  = 1'b1;
		do begin
			@(negedge clk);
			waited++;
		end while (!awready && waited < 10);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		if (!awready) begin
			report_fault($sformatf("write to %h was never accepted", addr));
		end else begin
			repeat (stall) begin
				@(negedge clk);
				assert (awready && wready && !bvalid)
					else report_fault("write handshake moved while bready low");
			end
			bready = 1'b1;
			@(negedge clk);
			bready = 1'b0;
			assert (bvalid) else report_fault("bvalid not one cycle after bready");
			resp = bresp;
		end
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [LANE_W-1:0] size,
		input int stall, output logic [DATA_W-1:0] data, output logic resp);
		int waited;
		resp    = 1'b0;
		data    = '0;
		waited  = 0;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		rsize   = size;
		do begin
			@(negedge clk);
			waited++;
		end while (!arready && waited < 10);
		arvalid = 1'b0;
		if (!arready) begin
			report_fault($sformatf("read from %h was never accepted", addr));
		end else begin
			repeat (stall) begin
				@(negedge clk);
				assert (arready && !rvalid)
					else report_fault("read handshake moved while rready low");
			end
			rready = 1'b1;
			@(negedge clk);
			rready = 1'b0;
			assert (rvalid) else report_fault("rvalid not one cycle after rready");
			data = rdata;
			resp = rresp;
		end
	endtask

	// address outside the window gets no ready
	task automatic check_ignored(input logic [ADDR_W-1:0] addr);
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = 32'hdead_beef;
		wstrb   = 4'hf;
		wvalid  = 1'b1;
		repeat (5) begin
			@(negedge clk);
			assert (!arready && !awready && !rvalid && !bvalid)
				else report_fault($sformatf("access to %h outside the window answered", addr));
		end
		arvalid = 1'b0;
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	assert property (@(posedge clk) disable iff (rst) rvalid |=> !rvalid)
		else report_fault("rvalid longer than one cycle");
	assert property (@(posedge clk) disable iff (rst) bvalid |=> !bvalid)
		else report_fault("bvalid longer than one cycle");
	assert property (@(posedge clk) disable iff (rst) awready == wready)
		else report_fault("awready and wready differ");
	assert property (@(posedge clk) disable iff (rst) rvalid |-> $past(arready && rready))
		else report_fault("rvalid without a read handshake");
	assert property (@(posedge clk) disable iff (rst) bvalid |-> $past(awready && bready))
		else report_fault("bvalid without a write handshake");
	assert property (@(posedge clk) disable iff (rst) rresp |-> rvalid)
		else report_fault("rresp outside rvalid");
	assert property (@(posedge clk) disable iff (rst) bresp |-> bvalid)
		else report_fault("bresp outside bvalid");

	initial begin : stimulus
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] got;
		logic              resp;
		int                ch;
		int                r;
		int                v;
		void'($urandom(98246));
		rst     = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		rsize   = '0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		pwm1    = 1'b0;
		pwm2    = 1'b0;
		for (ch = 0; ch < 2; ch++) begin
			for (r = 0; r < 5; r++) begin
				model[ch][r] = '0;
			end
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("reset handshake", '0, {arready, rvalid, rresp, awready, wready, bvalid, bresp});
		check_value("reset rdata", '0, rdata);
		check_outputs("reset");

		for (ch = 0; ch < 2; ch++) begin
			for (r = 0; r < 5; r++) begin
				d = $urandom();
				bus_write(reg_addr(ch, r), d, 4'hf, 0, resp);
				model_write(ch, r, d, 4'hf);
				check_value("word write bresp", 1, resp);
				check_outputs("word write");
				bus_read(reg_addr(ch, r), 4'hf, 0, got, resp);
				check_value("word read rresp", 1, resp);
				check_value("word read data", model[ch][r], got);
			end
		end

		// strobe 0100 still counts as a byte
		for (ch = 0; ch < 2; ch++) begin
			for (r = 0; r < 5; r++) begin
				d = $urandom();
				bus_write(reg_addr(ch, r), d, 4'b0100, 0, resp);
				model_write(ch, r, d, 4'b0100);
				check_value("byte write bresp", 1, resp);
				check_outputs("byte write");
				d = $urandom();
				bus_write(reg_addr(ch, r), d, 4'b0011, 0, resp);
				model_write(ch, r, d, 4'b0011);
				check_outputs("half write");
				bus_read(reg_addr(ch, r), 4'b0001, 0, got, resp);
				check_value("byte read", model[ch][r] & lane_mask_for(4'b0001), got);
				bus_read(reg_addr(ch, r), 4'b0110, 0, got, resp);
				check_value("half read", model[ch][r] & lane_mask_for(4'b0110), got);
			end
		end

		for (v = 0; v < 4; v++) begin
			@(negedge clk);
			pwm1 = v[0];
			pwm2 = v[1];
			repeat (2) @(negedge clk);  // let status settle
			bus_read(PWM_BASE_ADDR + 32'h28, 4'hf, 0, got, resp);
			check_value("status pwm1", {31'b0, pwm1}, got);
			bus_read(PWM_BASE_ADDR + 32'h2c, 4'hf, 0, got, resp);
			check_value("status pwm2", {31'b0, pwm2}, got);
		end

		foreach (bad_wr[i]) begin
			bus_write(PWM_BASE_ADDR + bad_wr[i], $urandom(), 4'hf, 0, resp);
			check_value("unmapped write bresp", 0, resp);
			check_outputs("unmapped write");
		end
		foreach (bad_rd[i]) begin
			bus_read(PWM_BASE_ADDR + bad_rd[i], 4'hf, 0, got, resp);
			check_value("unmapped read rresp", 0, resp);
		end
		check_ignored(32'h2003_0008);
		check_outputs("outside window");

		d = $urandom();
		bus_write(reg_addr(1, 1), d, 4'hf, 3 + ($urandom() % 8), resp);
		model_write(1, 1, d, 4'hf);
		check_value("stalled write bresp", 1, resp);
		check_outputs("stalled write");
		bus_read(reg_addr(1, 1), 4'hf, 3 + ($urandom() % 8), got, resp);
		check_value("stalled read data", model[1][1], got);

		repeat (3) @(negedge clk);
		$display("errors: %0d value, %0d protocol", val_errs, proto_errs);
		if (val_errs + proto_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WDOG_CYC) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WDOG_CYC);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/pwm_regs_pkg.sv
verilog/reg_access_if.sv
verilog/pwm_bus_ctrl.sv
verilog/pwm_channel_regs.sv
verilog/pwm_read_shaper.sv
verilog/pwm_axi_regs_top.sv
testbench/tb_pwm_axi_regs.sv
